// File: move_gen.f
source/chess_pkg.sv
source/move_fifo.sv
source/column_unit.sv
source/move_collector.sv
source/move_gen_top.sv
tests/move_gen_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = move_gen_tb
FILELIST = move_gen.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/move_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_tb;

	localparam int CLK_NS = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + chess_pkg::SCAN_CYCLES + 200);

	// flag bits of a move with invalid at the top
	localparam logic [6:0] F_PROMOTE = 7'b0100000;
	localparam logic [6:0] F_PAWN = 7'b0010000;
	localparam logic [6:0] F_TWO = 7'b0001000;
	localparam logic [6:0] F_CASTLE = 7'b0000010;
	localparam logic [6:0] F_CAPTURE = 7'b0000001;

	logic clk;
	logic reset;
	logic rd_en;
	chess_pkg::board_t board;
	chess_pkg::move_t move;
	logic empty;
	logic done;

	chess_pkg::board_t setup;
	chess_pkg::move_t exp_q[$];
	integer seed;

	move_gen_top u_move_gen_top (
		.clk(clk),
		.reset(reset),
		.board(board),
		.rd_en(rd_en),
		.move(move),
		.empty(empty),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_error("Timeout: the move generator did not finish in time");
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected)
			stop_with_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, expected));
	endtask

	function automatic logic [3:0] nibble(chess_pkg::board_t b, int f, int r);
		return b[(r * 8 + f) * 4 +: 4];
	endfunction

	function automatic logic is_vacant(chess_pkg::board_t b, int f, int r);
		logic [3:0] p;
		p = nibble(b, f, r);
		return p[2:0] == 3'd0;
	endfunction

	function automatic logic is_black(chess_pkg::board_t b, int f, int r);
		logic [3:0] p;
		p = nibble(b, f, r);
		return p[3] && (p[2:0] != 3'd0);
	endfunction

	// square layout is file above rank
	function automatic chess_pkg::move_t make_move(logic [6:0] flags, int ff, int fr, int tf, int tr);
		chess_pkg::move_t m;
		m.flags = flags;
		m.from = {3'(ff), 3'(fr)};
		m.to = {3'(tf), 3'(tr)};
		return m;
	endfunction

	task automatic place(input int f, input int r, input logic [3:0] p);
		setup[(r * 8 + f) * 4 +: 4] = p;
	endtask

	// expected order is castling, then files a..h, ranks up, kinds in scan order
	task automatic build_expected(input chess_pkg::board_t b);
		logic [6:0] promo;
		exp_q.delete();
		if (nibble(b, 4, 0) == 4'h6 && nibble(b, 7, 0) == 4'h4 && is_vacant(b, 5, 0) &&
			is_vacant(b, 6, 0))
			exp_q.push_back(make_move(F_CASTLE, 4, 0, 6, 0));
		if (nibble(b, 4, 0) == 4'h6 && nibble(b, 0, 0) == 4'h4 && is_vacant(b, 1, 0) &&
			is_vacant(b, 2, 0) && is_vacant(b, 3, 0))
			exp_q.push_back(make_move(F_CASTLE, 4, 0, 2, 0));
		for (int f = 0; f < 8; f++) begin
			for (int r = 0; r < 7; r++) begin
				if (nibble(b, f, r) == 4'h1) begin
					promo = (r + 1 == 7) ? F_PROMOTE : 7'd0;
					if (is_vacant(b, f, r + 1))
						exp_q.push_back(make_move(F_PAWN | promo, f, r, f, r + 1));
					if (r == 1 && is_vacant(b, f, 2) && is_vacant(b, f, 3))
						exp_q.push_back(make_move(F_PAWN | F_TWO, f, r, f, r + 2));
					if (f > 0 && is_black(b, f - 1, r + 1))
						exp_q.push_back(make_move(F_PAWN | F_CAPTURE | promo, f, r, f - 1, r + 1));
					if (f < 7 && is_black(b, f + 1, r + 1))
						exp_q.push_back(make_move(F_PAWN | F_CAPTURE | promo, f, r, f + 1, r + 1));
				end
			end
		end
	endtask

	// loads setup, resets the DUT and reads every move out
	task automatic run_board(input string name, input int max_gap);
		int n;
		int gap;
		logic finished_run;
		chess_pkg::move_t got;
		build_expected(setup);
		@(posedge clk);
		board <= setup;
		reset <= 1'b1;
		rd_en <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		n = 0;
		finished_run = 1'b0;
		while (!finished_run) begin
			@(negedge clk);
			if (done && empty) begin
				finished_run = 1'b1;
			end else if (!empty) begin
				got = move;
				if (n >= exp_q.size())
					stop_with_error($sformatf("%s: the DUT gave more moves than expected", name));
				check($sformatf("%s move[%0d]", name, n), 32'(got), 32'(exp_q[n]));
				n++;
				@(posedge clk);
				rd_en <= 1'b1;
				@(posedge clk);
				rd_en <= 1'b0;
				if (max_gap > 0) begin
					gap = $unsigned($random(seed)) % (max_gap + 1);
					repeat (gap) @(posedge clk);
				end
			end
		end
		check($sformatf("%s move count", name), n, exp_q.size());
		$display("%s: %0d moves", name, n);
	endtask

	task automatic test_empty_board();
		setup = '0;
		run_board("empty board", 0);
	endtask

	task automatic test_pushes();
		setup = '0;
		place(0, 1, 4'h1);
		// c2 blocked by its own knight
		place(2, 1, 4'h1);
		place(2, 2, 4'h2);
		place(4, 2, 4'h1);
		// g2 can only step once
		place(6, 1, 4'h1);
		place(6, 3, 4'hc);
		run_board("pushes", 0);
	endtask

	task automatic test_captures();
		setup = '0;
		place(0, 2, 4'h1);
		place(1, 3, 4'h9);
		// h4 and a4 would only be reached by wrapping over the edge
		place(7, 3, 4'hb);
		place(7, 2, 4'h1);
		place(6, 3, 4'ha);
		place(0, 3, 4'hd);
		place(3, 6, 4'h1);
		place(4, 7, 4'hc);
		place(2, 7, 4'hd);
		run_board("captures and promotion", 0);
	endtask

	task automatic test_castling();
		setup = '0;
		place(4, 0, 4'h6);
		place(0, 0, 4'h4);
		place(7, 0, 4'h4);
		place(4, 1, 4'h1);
		run_board("castling", 0);
	endtask

	task automatic test_castling_blocked();
		setup = '0;
		place(4, 0, 4'h6);
		place(0, 0, 4'h4);
		place(7, 0, 4'h4);
		place(6, 0, 4'h2);
		place(1, 1, 4'h1);
		run_board("castling blocked", 0);
	endtask

	task automatic test_random_board();
		int v;
		setup = '0;
		for (int r = 0; r < 8; r++) begin
			for (int f = 0; f < 8; f++) begin
				v = $unsigned($random(seed)) % 8;
				if (v == 4 || v == 5)
					place(f, r, 4'h1);
				else if (v == 6)
					place(f, r, {1'b1, 3'(1 + $unsigned($random(seed)) % 6)});
				else if (v == 7)
					place(f, r, {1'b0, 3'(2 + $unsigned($random(seed)) % 5)});
			end
		end
		run_board("random board", 3);
	endtask

	initial begin
		seed = 80115;
		reset <= 1'b1;
		rd_en <= 1'b0;
		board <= '0;
		test_empty_board();
		test_pushes();
		test_captures();
		test_castling();
		test_castling_blocked();
		test_random_board();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/move_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_top #(
	parameter int COL_FIFO_DEPTH = 16,
	parameter int OUT_FIFO_DEPTH = 128
) (
	input logic clk,
	input logic reset,
	input chess_pkg::board_t board,
	input logic rd_en,
	output chess_pkg::move_t move,
	output logic empty,
	output logic done
);

	logic [chess_pkg::NUM_FILES-1:0] col_wr;
	logic [chess_pkg::NUM_FILES-1:0] col_done;
	logic [chess_pkg::NUM_FILES-1:0] col_empty;
	logic [chess_pkg::NUM_FILES-1:0] col_rd;
	chess_pkg::move_t col_wr_move [chess_pkg::NUM_FILES];
	chess_pkg::move_t col_move [chess_pkg::NUM_FILES];

	logic out_wr;
	logic out_full;
	chess_pkg::move_t out_move;

	// one scanner and one queue per file
	genvar i;
	generate
		for (i = 0; i < chess_pkg::NUM_FILES; i++) begin : g_col
			column_unit u_column_unit (
				.clk(clk),
				.reset(reset),
				.file(chess_pkg::file_t'(i)),
				.board(board),
				.wr_en(col_wr[i]),
				.move(col_wr_move[i]),
				.col_done(col_done[i])
			);

			move_fifo #(.DEPTH(COL_FIFO_DEPTH)) u_col_fifo (
				.clk(clk),
				.reset(reset),
				.wr_en(col_wr[i]),
				.wr_data(col_wr_move[i]),
				.rd_en(col_rd[i]),
				.rd_data(col_move[i]),
				.empty(col_empty[i]),
				.full()
			);
		end
	endgenerate

	move_collector u_move_collector (
		.clk(clk),
		.reset(reset),
		.board(board),
		.col_done(col_done),
		.col_empty(col_empty),
		.col_move(col_move),
		.col_rd(col_rd),
		.out_full(out_full),
		.out_wr(out_wr),
		.out_move(out_move),
		.done(done)
	);

	move_fifo #(.DEPTH(OUT_FIFO_DEPTH)) u_out_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(out_wr),
		.wr_data(out_move),
		.rd_en(rd_en),
		.rd_data(move),
		.empty(empty),
		.full(out_full)
	);

endmodule

`default_nettype wire

// File: source/move_collector.sv
`timescale 1ns/1ps
`default_nettype none

module move_collector (
	input logic clk,
	input logic reset,
	input chess_pkg::board_t board,
	input logic [chess_pkg::NUM_FILES-1:0] col_done,
	input logic [chess_pkg::NUM_FILES-1:0] col_empty,
	input chess_pkg::move_t col_move [chess_pkg::NUM_FILES],
	output logic [chess_pkg::NUM_FILES-1:0] col_rd,
	input logic out_full,
	output logic out_wr,
	output chess_pkg::move_t out_move,
	output logic done
);

	localparam chess_pkg::file_t FILE_A = 3'd0;
	localparam chess_pkg::file_t FILE_B = 3'd1;
	localparam chess_pkg::file_t FILE_C = 3'd2;
	localparam chess_pkg::file_t FILE_D = 3'd3;
	localparam chess_pkg::file_t FILE_E = 3'd4;
	localparam chess_pkg::file_t FILE_F = 3'd5;
	localparam chess_pkg::file_t FILE_G = 3'd6;
	localparam chess_pkg::file_t FILE_H = 3'd7;
	localparam chess_pkg::rank_t BACK_RANK = 3'd0;
	localparam chess_pkg::piece_t WHITE_KING = {chess_pkg::WHITE, chess_pkg::KING};
	localparam chess_pkg::piece_t WHITE_ROOK = {chess_pkg::WHITE, chess_pkg::ROOK};

	typedef enum logic [2:0] {
		castle_king,
		castle_queen,
		wait_cols,
		drain,
		finished
	} state_t;

	state_t state;
	chess_pkg::file_t ptr;
	logic [chess_pkg::NUM_FILES-1:0] drained;
	logic [chess_pkg::NUM_FILES-1:0] cur_mask;
	logic king_ok;
	logic queen_ok;
	chess_pkg::move_t king_move;
	chess_pkg::move_t queen_move;

	function automatic logic back_empty(chess_pkg::board_t b, chess_pkg::file_t f);
		chess_pkg::piece_t p;
		p = chess_pkg::piece_at(b, f, BACK_RANK);
		return p[2:0] == chess_pkg::EMPTY;
	endfunction

	// simplified castling without check, attack or history tests
	assign king_ok = (chess_pkg::piece_at(board, FILE_E, BACK_RANK) == WHITE_KING) &&
		(chess_pkg::piece_at(board, FILE_H, BACK_RANK) == WHITE_ROOK) &&
		back_empty(board, FILE_F) && back_empty(board, FILE_G);
	assign queen_ok = (chess_pkg::piece_at(board, FILE_E, BACK_RANK) == WHITE_KING) &&
		(chess_pkg::piece_at(board, FILE_A, BACK_RANK) == WHITE_ROOK) &&
		back_empty(board, FILE_B) && back_empty(board, FILE_C) && back_empty(board, FILE_D);

	always_comb begin
		king_move = '0;
		king_move.flags.castle = 1'b1;
		king_move.from = chess_pkg::make_square(FILE_E, BACK_RANK);
		king_move.to = chess_pkg::make_square(FILE_G, BACK_RANK);
		queen_move = king_move;
		queen_move.to = chess_pkg::make_square(FILE_C, BACK_RANK);
	end

	assign cur_mask = chess_pkg::NUM_FILES'(1) << ptr;
	assign done = (state == finished);

	always_comb begin
		col_rd = '0;
		out_wr = 1'b0;
		out_move = col_move[ptr];
		case (state)
			castle_king: begin
				out_wr = king_ok;
				out_move = king_move;
			end
			castle_queen: begin
				out_wr = queen_ok;
				out_move = queen_move;
			end
			drain: begin
				// hold the column while the output queue is full
				if (!col_empty[ptr] && !out_full) begin
					col_rd = cur_mask;
					out_wr = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= castle_king;
			ptr <= FILE_A;
			drained <= '0;
		end else begin
			case (state)
				castle_king: state <= castle_queen;
				castle_queen: state <= wait_cols;
				wait_cols: begin
					if (&col_done)
						state <= drain;
				end
				drain: begin
					if (col_empty[ptr]) begin
						drained <= drained | cur_mask;
						if (&(drained | cur_mask))
							state <= finished;
						else
							ptr <= ptr + 3'd1;
					end
				end
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(col_rd))
		else $error("move_collector: col_rd not one-hot");
	// a column is only popped after every scan has finished
	assert property (@(posedge clk) disable iff (reset) (|col_rd) |-> (&col_done))
		else $error("move_collector: pop before scan end");

endmodule

`default_nettype wire

// File: source/column_unit.sv
`timescale 1ns/1ps
`default_nettype none

module column_unit (
	input logic clk,
	input logic reset,
	input chess_pkg::file_t file,
	input chess_pkg::board_t board,
	output logic wr_en,
	output chess_pkg::move_t move,
	output logic col_done
);

	localparam int SLOT_W = $clog2(chess_pkg::SCAN_CYCLES + 1);
	localparam chess_pkg::piece_t WHITE_PAWN = {chess_pkg::WHITE, chess_pkg::PAWN};
	localparam chess_pkg::rank_t LAST_RANK = 3'd7;
	localparam chess_pkg::rank_t DOUBLE_RANK = 3'd1;
	localparam chess_pkg::file_t LOW_EDGE = 3'd0;
	localparam chess_pkg::file_t HIGH_EDGE = 3'd7;

	// slot = rank * 4 + kind
	logic [SLOT_W-1:0] slot;
	logic scanning;
	chess_pkg::rank_t rank;
	chess_pkg::move_kind_t kind;

	chess_pkg::rank_t up1;
	chess_pkg::rank_t up2;
	chess_pkg::piece_t own;
	chess_pkg::piece_t ahead;
	chess_pkg::piece_t ahead2;
	chess_pkg::piece_t diag;
	chess_pkg::file_t diag_file;
	logic diag_ok;
	logic hit;
	chess_pkg::rank_t to_rank;
	chess_pkg::move_t next_move;

	assign scanning = (slot < SLOT_W'(chess_pkg::SCAN_CYCLES));
	assign col_done = (slot == SLOT_W'(chess_pkg::SCAN_CYCLES));
	assign rank = chess_pkg::rank_t'(slot >> 2);
	assign kind = chess_pkg::move_kind_t'(slot[1:0]);

	// up1 and up2 wrap on the top ranks where hit is masked
	assign up1 = rank + 3'd1;
	assign up2 = rank + 3'd2;
	assign own = chess_pkg::piece_at(board, file, rank);
	assign ahead = chess_pkg::piece_at(board, file, up1);
	assign ahead2 = chess_pkg::piece_at(board, file, up2);

	assign diag_file = (kind == chess_pkg::kind_capture_low) ? file - 3'd1 : file + 3'd1;
	assign diag_ok = (kind == chess_pkg::kind_capture_low) ? (file != LOW_EDGE) :
		(file != HIGH_EDGE);
	assign diag = chess_pkg::piece_at(board, diag_file, up1);

	always_comb begin
		next_move = '0;
		next_move.flags.pawn_move = 1'b1;
		next_move.from = chess_pkg::make_square(file, rank);
		to_rank = up1;
		hit = 1'b0;
		case (kind)
			chess_pkg::kind_push: begin
				hit = (ahead[2:0] == chess_pkg::EMPTY);
				next_move.to = chess_pkg::make_square(file, up1);
			end
			chess_pkg::kind_double: begin
				hit = (rank == DOUBLE_RANK) && (ahead[2:0] == chess_pkg::EMPTY) &&
					(ahead2[2:0] == chess_pkg::EMPTY);
				to_rank = up2;
				next_move.flags.pawn_two = 1'b1;
				next_move.to = chess_pkg::make_square(file, up2);
			end
			default: begin
				// any black piece on the diagonal can be taken
				hit = diag_ok && (diag[3] == chess_pkg::BLACK) &&
					(diag[2:0] != chess_pkg::EMPTY);
				next_move.flags.capture = 1'b1;
				next_move.to = chess_pkg::make_square(diag_file, up1);
			end
		endcase
		next_move.flags.promote = (to_rank == LAST_RANK);
		hit = hit && scanning && (own == WHITE_PAWN) && (rank != LAST_RANK);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			wr_en <= 1'b0;
		end else begin
			if (scanning)
				slot <= slot + 1'b1;
			wr_en <= hit;
		end
		move <= next_move;
	end

endmodule

`default_nettype wire

// File: source/move_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module move_fifo #(
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input chess_pkg::move_t wr_data,
	input logic rd_en,
	output chess_pkg::move_t rd_data,
	output logic empty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	chess_pkg::move_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head falls through
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// the writer must watch full and the reader empty
	assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
		else $error("move_fifo: push while full");
	assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
		else $error("move_fifo: pop while empty");

endmodule

`default_nettype wire

// File: source/chess_pkg.sv
`default_nettype none

package chess_pkg;

	localparam int NUM_FILES = 8;
	// 8 ranks times 4 move kinds
	localparam int SCAN_CYCLES = 32;

	typedef logic [255:0] board_t;
	typedef logic [3:0] piece_t;
	typedef logic [2:0] file_t;
	typedef logic [2:0] rank_t;
	// file in the upper 3 bits, rank in the lower 3
	typedef logic [5:0] square_t;

	// color bit of a piece
	localparam logic WHITE = 1'b0;
	localparam logic BLACK = 1'b1;

	// piece kinds in the low 3 bits of a square
	localparam logic [2:0] EMPTY = 3'd0;
	localparam logic [2:0] PAWN = 3'd1;
	localparam logic [2:0] KNIGHT = 3'd2;
	localparam logic [2:0] BISHOP = 3'd3;
	localparam logic [2:0] ROOK = 3'd4;
	localparam logic [2:0] QUEEN = 3'd5;
	localparam logic [2:0] KING = 3'd6;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_two;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	typedef struct packed {
		move_flags_t flags;
		square_t from;
		square_t to;
	} move_t;

	// scan order inside one rank
	typedef enum logic [1:0] {
		kind_push,
		kind_double,
		kind_capture_low,
		kind_capture_high
	} move_kind_t;

	function automatic piece_t piece_at(board_t board, file_t f, rank_t r);
		return board[{r, f, 2'b00} +: 4];
	endfunction

	function automatic square_t make_square(file_t f, rank_t r);
		return {f, r};
	endfunction

endpackage

`default_nettype wire
